// File: common/ring_pkg.sv
package ring_pkg;

    // ------------------------------
    // Flit layout
    // ------------------------------
    localparam int FLIT_W  = 64;
    localparam int POL_BIT = 63;   // Polarity, carried through unused
    localparam int DIR_BIT = 62;   // 0 cw, 1 ccw
    localparam int HOP_LSB = 48;
    localparam int HOP_MSB = 55;
    localparam int SRC_LSB = 32;
    localparam int SRC_MSB = 47;

    typedef logic [FLIT_W-1:0]          flit_t;
    typedef logic [HOP_MSB-HOP_LSB:0]   hop_t;
    typedef logic [SRC_MSB-SRC_LSB:0]   src_t;

    // ------------------------------
    // Port indices
    // ------------------------------
    localparam int PORT_CW  = 0;
    localparam int PORT_CCW = 1;
    localparam int PORT_PE  = 2;

    // One-hot requested output, indexed by PORT_*
    typedef logic [2:0] dest_t;

endpackage

// File: common/flit_req_if.sv
`timescale 1ns/1ps

// Pending flit of one input port and its route request to the switch
interface flit_req_if;

    logic             pending;   // Input buffer full
    ring_pkg::flit_t  flit;
    ring_pkg::dest_t  dest;
    logic             take;      // Granted, buffer empties at next edge

    modport port (
        output pending,
        output flit,
        output dest,
        input  take
    );

    modport switch (
        input  pending,
        input  flit,
        input  dest,
        output take
    );

endinterface

// File: src/input_port.sv
`timescale 1ns/1ps

module input_port #(
    parameter int PORT_ROLE = ring_pkg::PORT_CW   // Selects the route decode rule
) (
    input  logic             clk,
    input  logic             reset,
    input  ring_pkg::flit_t  in_flit,
    input  logic             in_strobe,
    output logic             in_ready,
    flit_req_if.port         req
);

    logic             full;
    ring_pkg::flit_t  buf_flit;
    ring_pkg::dest_t  route;
    logic             accept;

    assign in_ready = ~full;
    assign accept   = in_strobe & in_ready;

    // ------------------------------
    // Single-entry buffer
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            full <= 1'b0;
        end else if (accept) begin
            full <= 1'b1;
        end else if (req.take) begin
            full <= 1'b0;   // Ready again next cycle
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            buf_flit <= in_flit;
        end
    end

    // Route decode
    always_comb begin
        route = '0;
        if (PORT_ROLE == ring_pkg::PORT_PE) begin
            // Injection follows the direction bit
            route[ring_pkg::PORT_CW]  = ~buf_flit[ring_pkg::DIR_BIT];
            route[ring_pkg::PORT_CCW] = buf_flit[ring_pkg::DIR_BIT];
        end else if (buf_flit[ring_pkg::HOP_LSB]) begin
            route[PORT_ROLE] = 1'b1;           // Keep travelling
        end else begin
            route[ring_pkg::PORT_PE] = 1'b1;   // Eject to local PE
        end
    end

    assign req.pending = full;
    assign req.flit    = buf_flit;
    assign req.dest    = route;

endmodule

// File: switch/switch_alloc.sv
`timescale 1ns/1ps

module switch_alloc (
    input  logic             clk,
    input  logic             reset,
    flit_req_if.switch       cw_req,
    flit_req_if.switch       ccw_req,
    flit_req_if.switch       pe_req,
    input  logic             cw_free,
    input  logic             ccw_free,
    input  logic             pe_free,
    output logic             cw_wr,
    output logic             ccw_wr,
    output logic             pe_wr,
    output ring_pkg::flit_t  cw_wr_flit,
    output ring_pkg::flit_t  ccw_wr_flit,
    output ring_pkg::flit_t  pe_wr_flit
);

    logic [2:0] pri;     // Per output, 1 favours requester 1
    logic [1:0] g_cw;    // Req 0 cw in, req 1 pe in
    logic [1:0] g_ccw;   // Req 0 ccw in, req 1 pe in
    logic [1:0] g_pe;    // Req 0 cw in, req 1 ccw in

    // Two-way round robin, only while the output is free
    function automatic logic [1:0] rr_grant(
        input logic r0,
        input logic r1,
        input logic free,
        input logic pri_bit
    );
        logic [1:0] g;
        g[0] = free & r0 & (~r1 | ~pri_bit);
        g[1] = free & r1 & (~r0 | pri_bit);
        return g;
    endfunction

    // Hop field moves right one place per transfer
    function automatic ring_pkg::flit_t hop_shift(input ring_pkg::flit_t f);
        ring_pkg::flit_t o;
        ring_pkg::hop_t  hop;
        hop = f[ring_pkg::HOP_MSB:ring_pkg::HOP_LSB];
        o   = f;
        o[ring_pkg::HOP_MSB:ring_pkg::HOP_LSB] = hop >> 1;
        return o;
    endfunction

    // ------------------------------
    // Grants
    // ------------------------------
    assign g_cw = rr_grant(cw_req.pending & cw_req.dest[ring_pkg::PORT_CW],
                           pe_req.pending & pe_req.dest[ring_pkg::PORT_CW],
                           cw_free, pri[ring_pkg::PORT_CW]);

    assign g_ccw = rr_grant(ccw_req.pending & ccw_req.dest[ring_pkg::PORT_CCW],
                            pe_req.pending & pe_req.dest[ring_pkg::PORT_CCW],
                            ccw_free, pri[ring_pkg::PORT_CCW]);

    assign g_pe = rr_grant(cw_req.pending & cw_req.dest[ring_pkg::PORT_PE],
                           ccw_req.pending & ccw_req.dest[ring_pkg::PORT_PE],
                           pe_free, pri[ring_pkg::PORT_PE]);

    // Winner drops to lower priority
    always_ff @(posedge clk) begin
        if (reset) begin
            pri <= '0;
        end else begin
            if (|g_cw) pri[ring_pkg::PORT_CW] <= g_cw[0];
            if (|g_ccw) pri[ring_pkg::PORT_CCW] <= g_ccw[0];
            if (|g_pe) pri[ring_pkg::PORT_PE] <= g_pe[0];
        end
    end

    // Each input names one output, so at most one grant per input
    assign cw_req.take  = g_cw[0] | g_pe[0];
    assign ccw_req.take = g_ccw[0] | g_pe[1];
    assign pe_req.take  = g_cw[1] | g_ccw[1];

    // ------------------------------
    // Steering into output ports
    // ------------------------------
    assign cw_wr  = |g_cw;
    assign ccw_wr = |g_ccw;
    assign pe_wr  = |g_pe;

    assign cw_wr_flit  = hop_shift(g_cw[1] ? pe_req.flit : cw_req.flit);
    assign ccw_wr_flit = hop_shift(g_ccw[1] ? pe_req.flit : ccw_req.flit);
    assign pe_wr_flit  = hop_shift(g_pe[1] ? ccw_req.flit : cw_req.flit);

endmodule

// File: src/output_port.sv
`timescale 1ns/1ps

module output_port (
    input  logic             clk,
    input  logic             reset,
    input  logic             wr,
    input  ring_pkg::flit_t  wr_flit,
    output logic             free,
    output ring_pkg::flit_t  out_flit,
    output logic             out_strobe,
    input  logic             out_ready
);

    logic             full;
    ring_pkg::flit_t  data;

    // Switch writes only while free, so write and read never meet
    always_ff @(posedge clk) begin
        if (reset) begin
            full <= 1'b0;
        end else if (wr) begin
            full <= 1'b1;
        end else if (out_strobe && out_ready) begin
            full <= 1'b0;   // Taken downstream
        end
    end

    always_ff @(posedge clk) begin
        if (wr) begin
            data <= wr_flit;
        end
    end

    assign free       = ~full;
    assign out_strobe = full;   // Held until downstream ready
    assign out_flit   = data;

endmodule

// File: src/ring_router.sv
`timescale 1ns/1ps

module ring_router (
    input  logic             clk,
    input  logic             reset,
    // Ring and PE inputs
    input  ring_pkg::flit_t  cwdi,
    input  logic             cwsi,
    output logic             cwri,
    input  ring_pkg::flit_t  ccwdi,
    input  logic             ccwsi,
    output logic             ccwri,
    input  ring_pkg::flit_t  pedi,
    input  logic             pesi,
    output logic             peri,
    // Ring and PE outputs
    output ring_pkg::flit_t  cwdo,
    output logic             cwso,
    input  logic             cwro,
    output ring_pkg::flit_t  ccwdo,
    output logic             ccwso,
    input  logic             ccwro,
    output ring_pkg::flit_t  pedo,
    output logic             peso,
    input  logic             pero
);

    flit_req_if cw_req ();
    flit_req_if ccw_req ();
    flit_req_if pe_req ();

    logic             cw_wr, ccw_wr, pe_wr;
    logic             cw_free, ccw_free, pe_free;
    ring_pkg::flit_t  cw_wr_flit, ccw_wr_flit, pe_wr_flit;

    // ------------------------------
    // Input ports
    // ------------------------------
    input_port #(.PORT_ROLE(ring_pkg::PORT_CW)) u_cw_in (
        .clk(clk), .reset(reset),
        .in_flit(cwdi), .in_strobe(cwsi), .in_ready(cwri),
        .req(cw_req)
    );

    input_port #(.PORT_ROLE(ring_pkg::PORT_CCW)) u_ccw_in (
        .clk(clk), .reset(reset),
        .in_flit(ccwdi), .in_strobe(ccwsi), .in_ready(ccwri),
        .req(ccw_req)
    );

    input_port #(.PORT_ROLE(ring_pkg::PORT_PE)) u_pe_in (
        .clk(clk), .reset(reset),
        .in_flit(pedi), .in_strobe(pesi), .in_ready(peri),
        .req(pe_req)
    );

    // Switch
    switch_alloc u_switch (
        .clk(clk), .reset(reset),
        .cw_req(cw_req), .ccw_req(ccw_req), .pe_req(pe_req),
        .cw_free(cw_free), .ccw_free(ccw_free), .pe_free(pe_free),
        .cw_wr(cw_wr), .ccw_wr(ccw_wr), .pe_wr(pe_wr),
        .cw_wr_flit(cw_wr_flit), .ccw_wr_flit(ccw_wr_flit), .pe_wr_flit(pe_wr_flit)
    );

    // ------------------------------
    // Output ports
    // ------------------------------
    output_port u_cw_out (
        .clk(clk), .reset(reset),
        .wr(cw_wr), .wr_flit(cw_wr_flit), .free(cw_free),
        .out_flit(cwdo), .out_strobe(cwso), .out_ready(cwro)
    );

    output_port u_ccw_out (
        .clk(clk), .reset(reset),
        .wr(ccw_wr), .wr_flit(ccw_wr_flit), .free(ccw_free),
        .out_flit(ccwdo), .out_strobe(ccwso), .out_ready(ccwro)
    );

    output_port u_pe_out (
        .clk(clk), .reset(reset),
        .wr(pe_wr), .wr_flit(pe_wr_flit), .free(pe_free),
        .out_flit(pedo), .out_strobe(peso), .out_ready(pero)
    );

endmodule

// File: dv/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// ------------------------------
// Flit builders and port access
// ------------------------------

// Random fields with direction and hop low bit forced
function automatic ring_pkg::flit_t make_flit(input logic dir, input logic hop_lsb);
    ring_pkg::flit_t f;
    f = {$urandom, $urandom};
    f[ring_pkg::DIR_BIT] = dir;
    f[ring_pkg::HOP_LSB] = hop_lsb;
    return f;
endfunction

// Flit after one transfer with the hop moved right
function automatic ring_pkg::flit_t next_hop(input ring_pkg::flit_t f);
    ring_pkg::flit_t e;
    e = f;
    e[ring_pkg::HOP_MSB] = 1'b0;
    e[ring_pkg::HOP_MSB-1:ring_pkg::HOP_LSB] = f[ring_pkg::HOP_MSB:ring_pkg::HOP_LSB+1];
    return e;
endfunction

function automatic string port_name(input int port);
    case (port)
        ring_pkg::PORT_CW:  return "cw";
        ring_pkg::PORT_CCW: return "ccw";
        default:            return "pe";
    endcase
endfunction

function automatic logic in_rdy(input int port);
    case (port)
        ring_pkg::PORT_CW:  return cwri;
        ring_pkg::PORT_CCW: return ccwri;
        default:            return peri;
    endcase
endfunction

function automatic logic out_valid(input int port);
    case (port)
        ring_pkg::PORT_CW:  return cwso;
        ring_pkg::PORT_CCW: return ccwso;
        default:            return peso;
    endcase
endfunction

function automatic ring_pkg::flit_t out_data(input int port);
    case (port)
        ring_pkg::PORT_CW:  return cwdo;
        ring_pkg::PORT_CCW: return ccwdo;
        default:            return pedo;
    endcase
endfunction

task automatic drive_in(input int port, input ring_pkg::flit_t f, input logic s);
    case (port)
        ring_pkg::PORT_CW: begin
            cwdi = f;
            cwsi = s;
        end
        ring_pkg::PORT_CCW: begin
            ccwdi = f;
            ccwsi = s;
        end
        default: begin
            pedi = f;
            pesi = s;
        end
    endcase
endtask

task automatic apply_reset();
    @(negedge clk);
    reset = 1'b1;
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
endtask

// Waits for ready, then holds the strobe over one accepting edge
task automatic send_flit(input int port, input ring_pkg::flit_t f);
    int n;
    n = 0;
    while (!in_rdy(port)) begin
        @(negedge clk);
        n++;
        assert (n < 20) else stop_on_error({"Timed out waiting for ready on input ",
                                            port_name(port)});
    end
    drive_in(port, f, 1'b1);
    @(negedge clk);
    drive_in(port, f, 1'b0);
endtask

// Waits for the output strobe, checks the flit, then moves on one cycle
task automatic expect_out(input int port, input ring_pkg::flit_t exp, input int limit);
    int n;
    n = 0;
    while (!out_valid(port)) begin
        @(negedge clk);
        n++;
        assert (n <= limit) else stop_on_error({"Timed out waiting for strobe on output ",
                                                port_name(port)});
    end
    assert (out_data(port) === exp)
        else stop_on_error($sformatf("[FAIL] %0t: %0sdo got %h, expected %h",
                                     $time, port_name(port), out_data(port), exp));
    @(negedge clk);
endtask

// ------------------------------
// Directed tests
// ------------------------------
task automatic check_reset_state();
    assert (!cwso && !ccwso && !peso)
        else stop_on_error($sformatf("[FAIL] %0t: output strobe high after reset", $time));
    assert (cwri && ccwri && peri)
        else stop_on_error($sformatf("[FAIL] %0t: input ready low after reset", $time));
endtask

task automatic pass_ring_flits();
    ring_pkg::flit_t f;
    f = make_flit(1'b0, 1'b1);
    send_flit(ring_pkg::PORT_CW, f);
    expect_out(ring_pkg::PORT_CW, next_hop(f), 1);
    f = make_flit(1'b1, 1'b1);
    send_flit(ring_pkg::PORT_CCW, f);
    expect_out(ring_pkg::PORT_CCW, next_hop(f), 1);
endtask

task automatic eject_ring_flits();
    ring_pkg::flit_t f;
    f = make_flit(1'b0, 1'b0);   // Hop low bit clear so it leaves the ring
    send_flit(ring_pkg::PORT_CW, f);
    expect_out(ring_pkg::PORT_PE, next_hop(f), 1);
    f = make_flit(1'b1, 1'b0);
    send_flit(ring_pkg::PORT_CCW, f);
    expect_out(ring_pkg::PORT_PE, next_hop(f), 1);
endtask

task automatic inject_pe_flits();
    ring_pkg::flit_t f;
    f = make_flit(1'b0, 1'($urandom_range(1, 0)));
    send_flit(ring_pkg::PORT_PE, f);
    expect_out(ring_pkg::PORT_CW, next_hop(f), 1);
    f = make_flit(1'b1, 1'($urandom_range(1, 0)));
    send_flit(ring_pkg::PORT_PE, f);
    expect_out(ring_pkg::PORT_CCW, next_hop(f), 1);
endtask

task automatic hold_under_back_pressure();
    ring_pkg::flit_t f1;
    ring_pkg::flit_t f2;
    f1 = make_flit(1'b0, 1'b1);
    f2 = make_flit(1'b0, 1'b1);
    cwro = 1'b0;
    send_flit(ring_pkg::PORT_CW, f1);
    expect_out(ring_pkg::PORT_CW, next_hop(f1), 1);
    send_flit(ring_pkg::PORT_CW, f2);   // Parks in the input buffer
    repeat (4) begin
        assert (cwso && cwdo === next_hop(f1) && !cwri)
            else stop_on_error($sformatf("[FAIL] %0t: cw path did not hold under back-pressure",
                                         $time));
        @(negedge clk);
    end
    cwro = 1'b1;
    expect_out(ring_pkg::PORT_CW, next_hop(f1), 1);
    expect_out(ring_pkg::PORT_CW, next_hop(f2), 3);
    assert (cwri) else stop_on_error($sformatf("[FAIL] %0t: cwri still low after drain", $time));
endtask

// Both ring inputs eject together right after reset
task automatic arbitrate_contention();
    ring_pkg::flit_t fa;
    ring_pkg::flit_t fb;
    apply_reset();
    fa = make_flit(1'b0, 1'b0);
    fb = make_flit(1'b1, 1'b0);
    drive_in(ring_pkg::PORT_CW, fa, 1'b1);
    drive_in(ring_pkg::PORT_CCW, fb, 1'b1);
    @(negedge clk);
    drive_in(ring_pkg::PORT_CW, fa, 1'b0);
    drive_in(ring_pkg::PORT_CCW, fb, 1'b0);
    assert (!cwri && !ccwri)
        else stop_on_error($sformatf("[FAIL] %0t: inputs did not accept together", $time));
    expect_out(ring_pkg::PORT_PE, next_hop(fa), 2);
    expect_out(ring_pkg::PORT_PE, next_hop(fb), 3);
endtask

`endif

// File: dv/ring_router_tb.sv
`timescale 1ns/1ps

module ring_router_tb;

    logic             clk;
    logic             reset;
    ring_pkg::flit_t  cwdi, ccwdi, pedi;
    logic             cwsi, ccwsi, pesi;
    logic             cwri, ccwri, peri;
    ring_pkg::flit_t  cwdo, ccwdo, pedo;
    logic             cwso, ccwso, peso;
    logic             cwro, ccwro, pero;

    ring_router u_dut (
        .clk(clk), .reset(reset),
        .cwdi(cwdi), .cwsi(cwsi), .cwri(cwri),
        .ccwdi(ccwdi), .ccwsi(ccwsi), .ccwri(ccwri),
        .pedi(pedi), .pesi(pesi), .peri(peri),
        .cwdo(cwdo), .cwso(cwso), .cwro(cwro),
        .ccwdo(ccwdo), .ccwso(ccwso), .ccwro(ccwro),
        .pedo(pedo), .peso(peso), .pero(pero)
    );

    always #4 clk = ~clk;   // 8 ns period

    // Prints the cause, then the fail message, and stops
    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "Simulation stopped on first error");
    endtask

    `include "tb_tasks.svh"

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        cwdi  = '0;
        ccwdi = '0;
        pedi  = '0;
        cwsi  = 1'b0;
        ccwsi = 1'b0;
        pesi  = 1'b0;
        cwro  = 1'b1;   // Downstream always ready unless a test says otherwise
        ccwro = 1'b1;
        pero  = 1'b1;
        void'($urandom(6198));

        apply_reset();
        check_reset_state();
        pass_ring_flits();
        eject_ring_flits();
        inject_pe_flits();
        hold_under_back_pressure();
        arbitrate_contention();

        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+dv
common/ring_pkg.sv
common/flit_req_if.sv
src/input_port.sv
switch/switch_alloc.sv
src/output_port.sv
src/ring_router.sv
dv/ring_router_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the ring router testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module ring_router_tb \
    -Mdir obj_dir \
    -f filelist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vring_router_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0
